//--- sources.f
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/draw_bg.sv
verilog/object_table.sv
verilog/sprite_layer.sv
verilog/vga_out.sv
verilog/sprite_top.sv
test/tb_clock.sv
test/tb_sprite_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sprite_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_sprite_top.sv
`default_nettype none

module tb_sprite_top
    import vga_pkg::*;
;

    localparam int H_ACT = 64;
    localparam int H_FP = 4;
    localparam int H_SYNC = 8;
    localparam int H_BP = 4;
    localparam int V_ACT = 48;
    localparam int V_FP = 2;
    localparam int V_SYNC = 3;
    localparam int V_BP = 2;
    localparam int N_SPR = 3;
    localparam int ADDR_W = idx_w(N_SPR);
    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int CHECKED_FRAMES = 7;
    localparam int WATCHDOG_CYCLES = 8 * FRAME_CYCLES;

    logic              clk;
    logic              rst;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic              wr_field;
    obj_word_u         wr_data;
    logic              hs;
    logic              vs;
    logic              de;
    logic [3:0]        r;
    logic [3:0]        g;
    logic [3:0]        b;

    // Shadow of the object table, kept from the host writes below.
    bit sh_visible [N_SPR];
    int sh_x [N_SPR];
    int sh_y [N_SPR];
    int sh_w [N_SPR];
    int sh_h [N_SPR];
    int sh_rgb [N_SPR];

    int frames_checked = 0;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (.clk, .rst);

    sprite_top #(
        .H_ACTIVE(H_ACT), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACT), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .N_SPRITES(N_SPR)
    ) DUT (
        .clk, .rst, .wr_en, .wr_addr, .wr_field, .wr_data,
        .hs, .vs, .de, .r, .g, .b
    );

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------

    function automatic int expected_rgb(input int h, input int v);
        int c;
        int i;
        c = (h == 0 || h == H_ACT - 1 || v == 0 || v == V_ACT - 1) ?
            int'(BORDER_RGB) : int'(BG_RGB);
        for (i = 0; i < N_SPR; i++) begin
            if (sh_visible[i] && h >= sh_x[i] && h < sh_x[i] + sh_w[i] &&
                v >= sh_y[i] && v < sh_y[i] + sh_h[i]) begin
                c = sh_rgb[i];  // Later sprites land on top.
            end
        end
        return c;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %0d ('h%0h), expected %0d ('h%0h)",
                               $time, name, got, got, exp, exp));
        end
    endtask

    // ----------------------------------------
    // Host writes
    // ----------------------------------------

    task automatic write_word(input int idx, input logic field, input logic [31:0] word);
        if (vs !== 1'b1) begin
            fail_run("host write attempted while vs was low");
        end
        wr_en = 1'b1;
        wr_addr = ADDR_W'(idx);
        wr_field = field;
        wr_data = word;
        @(posedge clk);
        #DRIVE_DELAY;
        wr_en = 1'b0;
    endtask

    task automatic set_position(input int idx, input int vis, input int x, input int y);
        sh_visible[idx] = (vis != 0);
        sh_x[idx] = x;
        sh_y[idx] = y;
        write_word(idx, FIELD_POS, {(vis != 0), 9'd0, CNT_W'(x), CNT_W'(y)});
    endtask

    task automatic set_attributes(input int idx, input int w, input int h, input int rgb);
        sh_w[idx] = w;
        sh_h[idx] = h;
        sh_rgb[idx] = rgb;
        write_word(idx, FIELD_ATTR, {SIZE_W'(w), SIZE_W'(h), RGB_W'(rgb)});
    endtask

    task automatic randomize_sprites();
        int i;
        for (i = 0; i < N_SPR; i++) begin
            set_attributes(i, $urandom_range(40, 0), $urandom_range(30, 0),
                           $urandom_range('hfff, 0));
            set_position(i, $urandom_range(3, 0), $urandom_range(70, 0),
                         $urandom_range(52, 0));
        end
    endtask

    task automatic next_vblank();
        @(posedge vs);
        #DRIVE_DELAY;
    endtask

    initial begin : stimulus
        int i;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_field = FIELD_POS;
        wr_data = '0;
        for (i = 0; i < N_SPR; i++) begin
            sh_visible[i] = 1'b0;
            sh_x[i] = 0;
            sh_y[i] = 0;
            sh_w[i] = 0;
            sh_h[i] = 0;
            sh_rgb[i] = 0;
        end
        void'($urandom(32'hcdc6));
        wait (rst === 1'b0);
        next_vblank();  // The frame right after reset is not scanned.
        next_vblank();
        // Sprite 1 runs past the right and bottom edges; sprites 0 and 2 overlap.
        set_attributes(1, 10, 8, 'h0f0);
        set_position(1, 1, 58, 44);
        set_attributes(0, 20, 15, 'hf00);
        set_position(0, 1, 10, 10);
        set_attributes(2, 16, 12, 'h00f);
        set_position(2, 1, 20, 15);
        next_vblank();
        set_position(0, 1, 36, 24);  // Position view only.
        set_position(1, 0, 58, 44);
        next_vblank();
        set_position(1, 1, 2, 30);   // Size and colour survived while hidden.
        repeat (3) begin
            next_vblank();
            randomize_sprites();
        end
        next_vblank();
        wait (frames_checked == CHECKED_FRAMES);
        $display("Test passed");
        $finish;
    end

    // ----------------------------------------
    // Output monitors
    // ----------------------------------------

    // Pixel (0,0) is the first de cycle after vs falls.
    initial begin : pixel_scanner
        bit prev_vs;
        bit in_frame;
        int h;
        int v;
        prev_vs = 1'b0;
        in_frame = 1'b0;
        h = 0;
        v = 0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (prev_vs && !vs) begin
                    in_frame = 1'b1;
                    h = 0;
                    v = 0;
                end else if (!prev_vs && vs && in_frame) begin
                    check_value("rows scanned", v, V_ACT);
                    check_value("pixels left in last row", h, 0);
                    frames_checked++;
                    in_frame = 1'b0;
                end
                if (de && in_frame) begin
                    check_value($sformatf("rgb at pixel (%0d,%0d)", h, v),
                                int'({r, g, b}), expected_rgb(h, v));
                    h++;
                    if (h == H_ACT) begin
                        h = 0;
                        v++;
                    end
                end else if (!de) begin
                    check_value("rgb while de low", int'({r, g, b}), 0);
                end
                prev_vs = vs;
            end
        end
    end

    initial begin : sync_geometry
        bit prev_hs;
        bit prev_vs;
        bit prev_de;
        bit synced;
        bit hs_seen;
        bit vs_seen;
        int cyc;
        int hs_run;
        int vs_run;
        int de_run;
        int rows;
        int hs_rise;
        int vs_rise;
        {prev_hs, prev_vs, prev_de, synced, hs_seen, vs_seen} = '0;
        {cyc, hs_run, vs_run, de_run, rows, hs_rise, vs_rise} = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                cyc++;
                if (hs) hs_run++;
                if (vs) vs_run++;
                if (de) de_run++;
                if (hs && !prev_hs) begin
                    if (hs_seen) check_value("hs period", cyc - hs_rise, H_TOTAL);
                    hs_rise = cyc;
                    hs_seen = 1'b1;
                end
                if (!hs && prev_hs) begin
                    check_value("hs width", hs_run, H_SYNC);
                    hs_run = 0;
                end
                if (vs && !prev_vs) begin
                    if (vs_seen) check_value("vs period", cyc - vs_rise, FRAME_CYCLES);
                    if (synced) check_value("de rows per frame", rows, V_ACT);
                    vs_rise = cyc;
                    vs_seen = 1'b1;
                end
                if (!vs && prev_vs) begin
                    check_value("vs width", vs_run, V_SYNC * H_TOTAL);
                    vs_run = 0;
                    synced = 1'b1;  // Rows before the first vs are not aligned.
                    rows = 0;
                    de_run = 0;
                end
                if (!de && prev_de) begin
                    if (synced) begin
                        check_value("de cycles per row", de_run, H_ACT);
                        rows++;
                    end
                    de_run = 0;
                end
                prev_hs = hs;
                prev_vs = vs;
                prev_de = de;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Timeout: the frames did not finish in the allowed time");
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset drops just after a rising edge, like every other testbench input.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/sprite_top.sv
`default_nettype none

module sprite_top
    import vga_pkg::*;
#(
    parameter int H_ACTIVE  = 640,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33,
    parameter int N_SPRITES = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en,
    input  logic [idx_w(N_SPRITES)-1:0] wr_addr,
    input  logic                        wr_field,
    input  obj_word_u                   wr_data,
    output logic                        hs,
    output logic                        vs,
    output logic                        de,
    output logic [3:0]                  r,
    output logic [3:0]                  g,
    output logic [3:0]                  b
);

    logic [CNT_W-1:0] tim_hcount, tim_vcount;
    logic             tim_hsync, tim_vsync, tim_hblnk, tim_vblnk;

    // Stage k feeds sprite layer k. Entry N_SPRITES feeds the output stage.
    logic [CNT_W-1:0] hcount_s [N_SPRITES+1];
    logic [CNT_W-1:0] vcount_s [N_SPRITES+1];
    logic             hsync_s  [N_SPRITES+1];
    logic             vsync_s  [N_SPRITES+1];
    logic             hblnk_s  [N_SPRITES+1];
    logic             vblnk_s  [N_SPRITES+1];
    logic [RGB_W-1:0] rgb_s    [N_SPRITES+1];

    logic [N_SPRITES-1:0]             obj_visible;
    logic [N_SPRITES-1:0][CNT_W-1:0]  obj_x, obj_y;
    logic [N_SPRITES-1:0][SIZE_W-1:0] obj_width, obj_height;
    logic [N_SPRITES-1:0][RGB_W-1:0]  obj_rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_vga_timing (
        .clk, .rst,
        .hcount(tim_hcount), .vcount(tim_vcount),
        .hsync(tim_hsync), .vsync(tim_vsync),
        .hblnk(tim_hblnk), .vblnk(tim_vblnk)
    );

    draw_bg #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_draw_bg (
        .clk, .rst,
        .hcount_in(tim_hcount), .vcount_in(tim_vcount),
        .hsync_in(tim_hsync), .vsync_in(tim_vsync),
        .hblnk_in(tim_hblnk), .vblnk_in(tim_vblnk),
        .hcount_out(hcount_s[0]), .vcount_out(vcount_s[0]),
        .hsync_out(hsync_s[0]), .vsync_out(vsync_s[0]),
        .hblnk_out(hblnk_s[0]), .vblnk_out(vblnk_s[0]),
        .rgb_out(rgb_s[0])
    );

    object_table #(.N_SPRITES(N_SPRITES)) u_object_table (
        .clk, .rst, .wr_en, .wr_addr, .wr_field, .wr_data,
        .obj_visible, .obj_x, .obj_y, .obj_width, .obj_height, .obj_rgb
    );

    // ----------------------------------------
    // Sprite chain, higher index drawn on top
    // ----------------------------------------

    for (genvar i = 0; i < N_SPRITES; i++) begin : g_layer
        sprite_layer u_sprite_layer (
            .clk, .rst,
            .hcount_in(hcount_s[i]), .vcount_in(vcount_s[i]),
            .hsync_in(hsync_s[i]), .vsync_in(vsync_s[i]),
            .hblnk_in(hblnk_s[i]), .vblnk_in(vblnk_s[i]),
            .rgb_in(rgb_s[i]),
            .visible(obj_visible[i]), .x(obj_x[i]), .y(obj_y[i]),
            .width(obj_width[i]), .height(obj_height[i]), .rgb(obj_rgb[i]),
            .hcount_out(hcount_s[i+1]), .vcount_out(vcount_s[i+1]),
            .hsync_out(hsync_s[i+1]), .vsync_out(vsync_s[i+1]),
            .hblnk_out(hblnk_s[i+1]), .vblnk_out(vblnk_s[i+1]),
            .rgb_out(rgb_s[i+1])
        );
    end

    vga_out u_vga_out (
        .clk, .rst,
        .hsync_in(hsync_s[N_SPRITES]), .vsync_in(vsync_s[N_SPRITES]),
        .hblnk_in(hblnk_s[N_SPRITES]), .vblnk_in(vblnk_s[N_SPRITES]),
        .rgb_in(rgb_s[N_SPRITES]),
        .hs, .vs, .de, .r, .g, .b
    );

endmodule

`default_nettype wire

//--- verilog/vga_out.sv
`default_nettype none

module vga_out
    import vga_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             hblnk_in,
    input  logic             vblnk_in,
    input  logic [RGB_W-1:0] rgb_in,
    output logic             hs,
    output logic             vs,
    output logic             de,
    output logic [3:0]       r,
    output logic [3:0]       g,
    output logic [3:0]       b
);

    logic active;

    assign active = !(hblnk_in || vblnk_in);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs <= 1'b0;
            vs <= 1'b0;
            de <= 1'b0;
            r  <= '0;
            g  <= '0;
            b  <= '0;
        end else begin
            hs <= hsync_in;
            vs <= vsync_in;
            de <= active;
            // A monitor expects black during blanking.
            {r, g, b} <= active ? rgb_in : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sprite_layer.sv
`default_nettype none

module sprite_layer
    import vga_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [CNT_W-1:0]  hcount_in,
    input  logic [CNT_W-1:0]  vcount_in,
    input  logic              hsync_in,
    input  logic              vsync_in,
    input  logic              hblnk_in,
    input  logic              vblnk_in,
    input  logic [RGB_W-1:0]  rgb_in,
    input  logic              visible,
    input  logic [CNT_W-1:0]  x,
    input  logic [CNT_W-1:0]  y,
    input  logic [SIZE_W-1:0] width,
    input  logic [SIZE_W-1:0] height,
    input  logic [RGB_W-1:0]  rgb,
    output logic [CNT_W-1:0]  hcount_out,
    output logic [CNT_W-1:0]  vcount_out,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              hblnk_out,
    output logic              vblnk_out,
    output logic [RGB_W-1:0]  rgb_out
);

    logic [CNT_W:0] x_end;  // One bit wider so x plus width cannot wrap.
    logic [CNT_W:0] y_end;
    logic           in_x;
    logic           in_y;

    assign x_end = {1'b0, x} + (CNT_W + 1)'(width);
    assign y_end = {1'b0, y} + (CNT_W + 1)'(height);

    assign in_x = (hcount_in >= x) && ({1'b0, hcount_in} < x_end);
    assign in_y = (vcount_in >= y) && ({1'b0, vcount_in} < y_end);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= (visible && in_x && in_y) ? rgb : rgb_in;
        end
    end

    // The timing generator must place the sync pulse inside the blanking interval.
    a_hsync_in_blank: assert property (
        @(posedge clk) disable iff (rst) hsync_in |-> hblnk_in
    );

endmodule

`default_nettype wire

//--- verilog/object_table.sv
`default_nettype none

module object_table
    import vga_pkg::*;
#(
    parameter int N_SPRITES = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr_en,
    input  logic [idx_w(N_SPRITES)-1:0]          wr_addr,
    input  logic                                 wr_field,
    input  obj_word_u                            wr_data,
    output logic [N_SPRITES-1:0]                 obj_visible,
    output logic [N_SPRITES-1:0][CNT_W-1:0]      obj_x,
    output logic [N_SPRITES-1:0][CNT_W-1:0]      obj_y,
    output logic [N_SPRITES-1:0][SIZE_W-1:0]     obj_width,
    output logic [N_SPRITES-1:0][SIZE_W-1:0]     obj_height,
    output logic [N_SPRITES-1:0][RGB_W-1:0]      obj_rgb
);

    // ----------------------------------------
    // Position view
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_visible <= '0;
            obj_x       <= '0;
            obj_y       <= '0;
        end else if (wr_en && (wr_field == FIELD_POS)) begin
            obj_visible[wr_addr] <= wr_data.pos.visible;
            obj_x[wr_addr]       <= wr_data.pos.x;
            obj_y[wr_addr]       <= wr_data.pos.y;
        end
    end

    // ----------------------------------------
    // Attribute view
    // ----------------------------------------

    // The other view of the same entry is left untouched.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_width  <= '0;
            obj_height <= '0;
            obj_rgb    <= '0;
        end else if (wr_en && (wr_field == FIELD_ATTR)) begin
            obj_width[wr_addr]  <= wr_data.attr.width;
            obj_height[wr_addr] <= wr_data.attr.height;
            obj_rgb[wr_addr]    <= wr_data.attr.rgb;
        end
    end

    // A host must never address an entry the table does not have.
    a_wr_addr_range: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> (int'(wr_addr) < N_SPRITES)
    );

endmodule

`default_nettype wire

//--- verilog/draw_bg.sv
`default_nettype none

module draw_bg
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [CNT_W-1:0] hcount_in,
    input  logic [CNT_W-1:0] vcount_in,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             hblnk_in,
    input  logic             vblnk_in,
    output logic [CNT_W-1:0] hcount_out,
    output logic [CNT_W-1:0] vcount_out,
    output logic             hsync_out,
    output logic             vsync_out,
    output logic             hblnk_out,
    output logic             vblnk_out,
    output logic [RGB_W-1:0] rgb_out
);

    logic on_border;

    assign on_border = (hcount_in == '0) || (hcount_in == CNT_W'(H_ACTIVE - 1)) ||
                       (vcount_in == '0) || (vcount_in == CNT_W'(V_ACTIVE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= on_border ? BORDER_RGB : BG_RGB;  // Blanked later anyway.
        end
    end

endmodule

`default_nettype wire

//--- verilog/vga_timing.sv
`default_nettype none

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33
) (
    input  logic             clk,
    input  logic             rst,
    output logic [CNT_W-1:0] hcount,
    output logic [CNT_W-1:0] vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             hblnk,
    output logic             vblnk
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam logic [CNT_W-1:0] H_LAST   = CNT_W'(H_TOTAL - 1);
    localparam logic [CNT_W-1:0] V_LAST   = CNT_W'(V_TOTAL - 1);
    localparam logic [CNT_W-1:0] HS_START = CNT_W'(H_ACTIVE + H_FP);
    localparam logic [CNT_W-1:0] HS_END   = CNT_W'(H_ACTIVE + H_FP + H_SYNC);
    localparam logic [CNT_W-1:0] VS_START = CNT_W'(V_ACTIVE + V_FP);
    localparam logic [CNT_W-1:0] VS_END   = CNT_W'(V_ACTIVE + V_FP + V_SYNC);

    logic [CNT_W-1:0] hcount_nxt;
    logic [CNT_W-1:0] vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + CNT_W'(1);
        vcount_nxt = vcount;
        if (hcount == H_LAST) begin
            hcount_nxt = '0;
            vcount_nxt = (vcount == V_LAST) ? '0 : vcount + CNT_W'(1);
        end
    end

    // Flags are decoded from the next count so they line up with the counters.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= (hcount_nxt >= CNT_W'(H_ACTIVE));
            vblnk  <= (vcount_nxt >= CNT_W'(V_ACTIVE));
            hsync  <= (hcount_nxt >= HS_START) && (hcount_nxt < HS_END);
            vsync  <= (vcount_nxt >= VS_START) && (vcount_nxt < VS_END);
        end
    end

    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst) hcount <= H_LAST
    );

endmodule

`default_nettype wire

//--- verilog/vga_pkg.sv
`default_nettype none

package vga_pkg;

    localparam int CNT_W  = 11;  // Pixel and line counters, sprite coordinates.
    localparam int RGB_W  = 12;
    localparam int SIZE_W = 10;  // Sprite width and height.

    localparam logic [RGB_W-1:0] BG_RGB     = 12'h136;
    localparam logic [RGB_W-1:0] BORDER_RGB = 12'hfc0;

    // Selects which view of the object word a host write updates.
    localparam logic FIELD_POS  = 1'b0;
    localparam logic FIELD_ATTR = 1'b1;

    typedef struct packed {
        logic             visible;
        logic [8:0]       reserved;
        logic [CNT_W-1:0] x;
        logic [CNT_W-1:0] y;
    } obj_pos_t;

    typedef struct packed {
        logic [SIZE_W-1:0] width;
        logic [SIZE_W-1:0] height;
        logic [RGB_W-1:0]  rgb;
    } obj_attr_t;

    // One 32-bit write word, read either as a position or as attributes.
    typedef union packed {
        obj_pos_t  pos;
        obj_attr_t attr;
    } obj_word_u;

    // Index width for a table of n entries, never narrower than one bit.
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire
